// File: hw/issue_pkg.sv
`default_nettype none

package issue_pkg;

	localparam int NUM_REGS = 32;
	localparam int NUM_SLOTS = 3;
	localparam int NUM_LANES = 2;
	localparam int REG_W = 5;
	localparam int DATA_W = 32;
	localparam int IMM_W = 16;

	typedef logic [REG_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] word_t;

	// shifts use the low bits of the second operand
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_ADDI
	} opcode_t;

	// decoded micro-op from the source
	typedef struct packed {
		opcode_t op;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [IMM_W-1:0] imm;
	} uop_t;

	// operands already resolved, b holds the immediate for addi
	typedef struct packed {
		opcode_t op;
		reg_addr_t rd;
		word_t a;
		word_t b;
	} issue_t;

endpackage

`default_nettype wire

// File: hw/exec_if.sv
`timescale 1ns/10ps
`default_nettype none

interface exec_if;
	import issue_pkg::*;

	// one-cycle strobe per issued op
	logic valid;
	opcode_t op;
	reg_addr_t rd;
	word_t a;
	word_t b;

	modport sender (
		output valid, op, rd, a, b
	);

	modport receiver (
		input valid, op, rd, a, b
	);

endinterface

`default_nettype wire

// File: hw/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface wb_if;
	import issue_pkg::*;

	// one entry per lane, each driven by its own alu lane
	logic valid [NUM_LANES];
	reg_addr_t rd [NUM_LANES];
	word_t data [NUM_LANES];

	modport sender (
		output valid, rd, data
	);

	modport receiver (
		input valid, rd, data
	);

endinterface

`default_nettype wire

// File: hw/issue_window.sv
`timescale 1ns/10ps
`default_nettype none

module issue_window (
	input wire logic clk,
	input wire logic rstn,
	input wire logic i_valid,
	input wire logic [1:0] i_en,
	input wire issue_pkg::uop_t i_uop0,
	input wire issue_pkg::uop_t i_uop1,
	input wire logic [issue_pkg::NUM_SLOTS-1:0] i_issued,
	output logic [issue_pkg::NUM_SLOTS-1:0] o_slot_valid,
	output issue_pkg::uop_t o_slot_uop [issue_pkg::NUM_SLOTS],
	output logic o_busy
);
	import issue_pkg::*;

	logic [NUM_SLOTS-1:0] slot_valid_q;
	uop_t slot_uop_q [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] keep;
	logic accept;
	logic [NUM_SLOTS-1:0] nxt_valid;
	uop_t nxt_uop [NUM_SLOTS];

	// slots still occupied after this cycle's issue
	assign keep = slot_valid_q & ~i_issued;

	// two survivors leave room for one op only
	assign o_busy = $countones(keep) >= 2;
	assign accept = i_valid && !o_busy;

	// survivors slide down in age order, new ops stack above them
	always_comb begin
		logic [1:0] n;
		n = '0;
		nxt_valid = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			nxt_uop[k] = slot_uop_q[k];
		end
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (keep[k]) begin
				nxt_valid[n] = 1'b1;
				nxt_uop[n] = slot_uop_q[k];
				n = n + 2'd1;
			end
		end
		if (accept && i_en[0]) begin
			nxt_valid[n] = 1'b1;
			nxt_uop[n] = i_uop0;
			n = n + 2'd1;
		end
		if (accept && i_en[1]) begin
			nxt_valid[n] = 1'b1;
			nxt_uop[n] = i_uop1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			slot_valid_q <= '0;
		end else begin
			slot_valid_q <= nxt_valid;
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			slot_uop_q[k] <= nxt_uop[k];
		end
	end

	assign o_slot_valid = slot_valid_q;
	assign o_slot_uop = slot_uop_q;

endmodule

`default_nettype wire

// File: hw/issue_select.sv
`timescale 1ns/10ps
`default_nettype none

module issue_select (
	input wire logic clk,
	input wire logic rstn,
	input wire logic [issue_pkg::NUM_SLOTS-1:0] i_slot_valid,
	input wire issue_pkg::uop_t i_slot_uop [issue_pkg::NUM_SLOTS],
	input wire issue_pkg::word_t i_rd_data [2*issue_pkg::NUM_LANES],
	output logic [issue_pkg::NUM_SLOTS-1:0] o_issued,
	output issue_pkg::reg_addr_t o_rd_addr [2*issue_pkg::NUM_LANES],
	wb_if.receiver wb,
	exec_if.sender ex0,
	exec_if.sender ex1
);
	import issue_pkg::*;

	logic [NUM_REGS-1:0] pending_q;
	logic [NUM_REGS-1:0] wb_mask;
	logic [NUM_REGS-1:0] pend_eff;
	logic [NUM_REGS-1:0] set_mask;
	logic [NUM_SLOTS-1:0] ready;
	logic [NUM_SLOTS-1:0] grant [NUM_LANES];
	uop_t lane_uop [NUM_LANES];
	issue_t lane_iss [NUM_LANES];

	// r0 never tracked
	function automatic logic [NUM_REGS-1:0] reg_bit(input reg_addr_t r);
		logic [NUM_REGS-1:0] m;
		m = '0;
		if (r != '0)
			m[r] = 1'b1;
		return m;
	endfunction

	always_comb begin
		wb_mask = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (wb.valid[l])
				wb_mask = wb_mask | reg_bit(wb.rd[l]);
		end
	end

	// a returning result frees its register in the same cycle
	assign pend_eff = pending_q & ~wb_mask;

	always_comb begin
		logic [NUM_REGS-1:0] older_dst;
		logic [NUM_REGS-1:0] older_src;
		logic [NUM_REGS-1:0] src;
		logic [NUM_REGS-1:0] dst;
		older_dst = '0;
		older_src = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			src = reg_bit(i_slot_uop[k].rs);
			if (i_slot_uop[k].op != OP_ADDI)
				src = src | reg_bit(i_slot_uop[k].rt);
			dst = reg_bit(i_slot_uop[k].rd);
			ready[k] = i_slot_valid[k]
				&& (((src | dst) & (pend_eff | older_dst)) == '0)
				&& ((dst & older_src) == '0);
			if (i_slot_valid[k]) begin
				older_dst = older_dst | dst;
				older_src = older_src | src;
			end
		end
	end

	// oldest ready slot to lane 0, next one to lane 1
	always_comb begin
		grant[0] = '0;
		grant[1] = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (ready[k] && grant[0] == '0)
				grant[0][k] = 1'b1;
			else if (ready[k] && grant[1] == '0)
				grant[1][k] = 1'b1;
		end
	end

	assign o_issued = grant[0] | grant[1];

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_uop[l] = '0;
			for (int k = 0; k < NUM_SLOTS; k++) begin
				if (grant[l][k])
					lane_uop[l] = i_slot_uop[k];
			end
			o_rd_addr[2*l] = lane_uop[l].rs;
			o_rd_addr[2*l+1] = lane_uop[l].rt;
			lane_iss[l].op = lane_uop[l].op;
			lane_iss[l].rd = lane_uop[l].rd;
			lane_iss[l].a = i_rd_data[2*l];
			if (lane_uop[l].op == OP_ADDI)
				lane_iss[l].b = {{(DATA_W-IMM_W){lane_uop[l].imm[IMM_W-1]}}, lane_uop[l].imm};
			else
				lane_iss[l].b = i_rd_data[2*l+1];
		end
	end

	always_comb begin
		set_mask = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (grant[l] != '0)
				set_mask = set_mask | reg_bit(lane_uop[l].rd);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pending_q <= '0;
			ex0.valid <= 1'b0;
			ex1.valid <= 1'b0;
		end else begin
			pending_q <= pend_eff | set_mask;
			ex0.valid <= grant[0] != '0;
			ex1.valid <= grant[1] != '0;
		end
	end

	always_ff @(posedge clk) begin
		ex0.op <= lane_iss[0].op;
		ex0.rd <= lane_iss[0].rd;
		ex0.a <= lane_iss[0].a;
		ex0.b <= lane_iss[0].b;
		ex1.op <= lane_iss[1].op;
		ex1.rd <= lane_iss[1].rd;
		ex1.a <= lane_iss[1].a;
		ex1.b <= lane_iss[1].b;
	end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic rstn,
	input wire issue_pkg::reg_addr_t i_rd_addr [2*issue_pkg::NUM_LANES],
	output issue_pkg::word_t o_rd_data [2*issue_pkg::NUM_LANES],
	wb_if.receiver wb
);
	import issue_pkg::*;

	word_t regs [NUM_REGS];

	// all registers start at zero
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (wb.valid[l])
					regs[wb.rd[l]] <= wb.data[l];
			end
		end
	end

	// bypass from the write-back bus, r0 reads zero
	always_comb begin
		for (int p = 0; p < 2*NUM_LANES; p++) begin
			o_rd_data[p] = regs[i_rd_addr[p]];
			for (int l = 0; l < NUM_LANES; l++) begin
				if (wb.valid[l] && wb.rd[l] == i_rd_addr[p])
					o_rd_data[p] = wb.data[l];
			end
			if (i_rd_addr[p] == '0)
				o_rd_data[p] = '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/alu_lane.sv
`timescale 1ns/10ps
`default_nettype none

module alu_lane #(
	parameter int LANE = 0
) (
	input wire logic clk,
	input wire logic rstn,
	exec_if.receiver ex,
	wb_if.sender wb
);
	import issue_pkg::*;

	word_t res;
	logic valid_q;
	reg_addr_t rd_q;
	word_t data_q;

	always_comb begin
		case (ex.op)
			OP_ADD, OP_ADDI: res = ex.a + ex.b;
			OP_SUB: res = ex.a - ex.b;
			OP_AND: res = ex.a & ex.b;
			OP_OR: res = ex.a | ex.b;
			OP_XOR: res = ex.a ^ ex.b;
			OP_SLL: res = ex.a << ex.b[REG_W-1:0];
			OP_SRL: res = ex.a >> ex.b[REG_W-1:0];
			default: res = '0;
		endcase
	end

	// writes to r0 are dropped here
	always_ff @(posedge clk) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= ex.valid && ex.rd != '0;
		end
	end

	always_ff @(posedge clk) begin
		rd_q <= ex.rd;
		data_q <= res;
	end

	assign wb.valid[LANE] = valid_q;
	assign wb.rd[LANE] = rd_q;
	assign wb.data[LANE] = data_q;

endmodule

`default_nettype wire

// File: hw/issue_core.sv
`timescale 1ns/10ps
`default_nettype none

module issue_core (
	input wire logic clk,
	input wire logic rstn,
	input wire logic i_valid,
	input wire logic [1:0] i_en,
	input wire issue_pkg::uop_t i_uop0,
	input wire issue_pkg::uop_t i_uop1,
	output logic o_busy,
	output logic [issue_pkg::NUM_LANES-1:0] o_wb_valid,
	output issue_pkg::reg_addr_t o_wb_rd [issue_pkg::NUM_LANES],
	output issue_pkg::word_t o_wb_data [issue_pkg::NUM_LANES]
);
	import issue_pkg::*;

	logic [NUM_SLOTS-1:0] slot_valid;
	uop_t slot_uop [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] issued;
	reg_addr_t rd_addr [2*NUM_LANES];
	word_t rd_data [2*NUM_LANES];

	exec_if ex0 ();
	exec_if ex1 ();
	wb_if wb ();

	issue_window u_window (
		.clk(clk),
		.rstn(rstn),
		.i_valid(i_valid),
		.i_en(i_en),
		.i_uop0(i_uop0),
		.i_uop1(i_uop1),
		.i_issued(issued),
		.o_slot_valid(slot_valid),
		.o_slot_uop(slot_uop),
		.o_busy(o_busy)
	);

	issue_select u_select (
		.clk(clk),
		.rstn(rstn),
		.i_slot_valid(slot_valid),
		.i_slot_uop(slot_uop),
		.i_rd_data(rd_data),
		.o_issued(issued),
		.o_rd_addr(rd_addr),
		.wb(wb),
		.ex0(ex0),
		.ex1(ex1)
	);

	reg_file u_regs (
		.clk(clk),
		.rstn(rstn),
		.i_rd_addr(rd_addr),
		.o_rd_data(rd_data),
		.wb(wb)
	);

	alu_lane #(.LANE(0)) u_alu0 (
		.clk(clk),
		.rstn(rstn),
		.ex(ex0),
		.wb(wb)
	);

	alu_lane #(.LANE(1)) u_alu1 (
		.clk(clk),
		.rstn(rstn),
		.ex(ex1),
		.wb(wb)
	);

	assign o_wb_valid[0] = wb.valid[0];
	assign o_wb_valid[1] = wb.valid[1];
	assign o_wb_rd = wb.rd;
	assign o_wb_data = wb.data;

endmodule

`default_nettype wire

// File: sim/tb_issue_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_issue_core;
	import issue_pkg::*;

	localparam int QDEPTH = 16;
	localparam int NUM_RANDOM = 60;

	logic clk;
	logic rstn;
	logic i_valid;
	logic [1:0] i_en;
	uop_t i_uop0;
	uop_t i_uop1;
	logic o_busy;
	logic [NUM_LANES-1:0] o_wb_valid;
	reg_addr_t o_wb_rd [NUM_LANES];
	word_t o_wb_data [NUM_LANES];

	// sequential model and one circular queue per register
	word_t model_regs [NUM_REGS];
	word_t exp_val [NUM_REGS][QDEPTH];
	int exp_edge [NUM_REGS][QDEPTH];
	int q_head [NUM_REGS];
	int q_tail [NUM_REGS];
	int errors;
	int cyc = 0;
	int ops_sent;
	int exp_wb;
	int wb_count;
	int seed;

	issue_core dut0 (
		.clk(clk),
		.rstn(rstn),
		.i_valid(i_valid),
		.i_en(i_en),
		.i_uop0(i_uop0),
		.i_uop1(i_uop1),
		.o_busy(o_busy),
		.o_wb_valid(o_wb_valid),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("failure at %0t: %s", $time, what);
	endtask

	function automatic uop_t make_uop(input opcode_t op, input int rd, input int rs,
			input int rt, input int imm);
		uop_t u;
		u.op = op;
		u.rd = reg_addr_t'(rd);
		u.rs = reg_addr_t'(rs);
		u.rt = reg_addr_t'(rt);
		u.imm = 16'(imm);
		return u;
	endfunction

	function automatic word_t expected_result(input uop_t u);
		word_t a;
		word_t b;
		word_t r;
		a = model_regs[u.rs];
		b = model_regs[u.rt];
		case (u.op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_XOR: r = a ^ b;
			OP_SLL: r = a << b[4:0];
			OP_SRL: r = a >> b[4:0];
			default: r = a + {{16{u.imm[15]}}, u.imm};
		endcase
		return r;
	endfunction

	task automatic model_step(input uop_t u, input int edge_no);
		word_t r;
		r = expected_result(u);
		ops_sent++;
		if (u.rd != '0) begin
			model_regs[u.rd] = r;
			if (q_tail[u.rd] - q_head[u.rd] >= QDEPTH)
				report_failure("expectation queue overflowed");
			exp_val[u.rd][q_tail[u.rd] % QDEPTH] = r;
			exp_edge[u.rd][q_tail[u.rd] % QDEPTH] = edge_no;
			q_tail[u.rd]++;
			exp_wb++;
		end
	endtask

	// called and returns on a falling edge
	task automatic send_pair(input uop_t u0, input uop_t u1, input logic [1:0] en);
		while (o_busy)
			@(negedge clk);
		i_valid = 1'b1;
		i_en = en;
		i_uop0 = u0;
		i_uop1 = u1;
		if (en[0])
			model_step(u0, cyc + 1);
		if (en[1])
			model_step(u1, cyc + 1);
		@(negedge clk);
		i_valid = 1'b0;
		i_en = 2'b00;
	endtask

	task automatic take_writeback(input reg_addr_t rd, input word_t data);
		int slot;
		wb_count++;
		if (rd == '0) begin
			report_failure("write-back seen for register 0");
		end else if (q_head[rd] == q_tail[rd]) begin
			report_failure($sformatf("write-back to r%0d with no expected value", rd));
		end else begin
			slot = q_head[rd] % QDEPTH;
			check_value($sformatf("o_wb_data for r%0d", rd), data, exp_val[rd][slot]);
			// the valid seen here is sampled at the coming rising edge
			if (cyc + 1 < exp_edge[rd][slot] + 3)
				report_failure($sformatf("write-back to r%0d arrived too early", rd));
			q_head[rd]++;
		end
	endtask

	// monitor pops one expectation per write-back
	always @(negedge clk) begin
		if (rstn) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (o_wb_valid[l] === 1'b1)
					take_writeback(o_wb_rd[l], o_wb_data[l]);
			end
		end
	end

	task automatic wait_drain();
		int left;
		left = 1;
		while (left != 0) begin
			@(negedge clk);
			left = 0;
			for (int r = 0; r < NUM_REGS; r++)
				left += q_tail[r] - q_head[r];
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic reset_idle();
		repeat (10) begin
			@(negedge clk);
			check_value("o_busy", o_busy, 0);
			check_value("o_wb_valid", o_wb_valid, 0);
		end
	endtask

	task automatic each_operation();
		send_pair(make_uop(OP_ADDI, 1, 0, 0, 'h1234),
			make_uop(OP_ADDI, 2, 0, 0, 'hfffb), 2'b11);
		send_pair(make_uop(OP_ADDI, 3, 0, 0, 7),
			make_uop(OP_ADDI, 4, 0, 0, 'h7fff), 2'b11);
		send_pair(make_uop(OP_ADD, 10, 1, 2, 0), make_uop(OP_SUB, 11, 1, 2, 0), 2'b11);
		send_pair(make_uop(OP_AND, 12, 1, 2, 0), make_uop(OP_OR, 13, 1, 3, 0), 2'b11);
		send_pair(make_uop(OP_XOR, 14, 2, 4, 0), make_uop(OP_SLL, 15, 4, 3, 0), 2'b11);
		send_pair(make_uop(OP_SRL, 16, 2, 3, 0),
			make_uop(OP_ADDI, 17, 1, 0, 'h8001), 2'b11);
		wait_drain();
	endtask

	task automatic raw_chains();
		send_pair(make_uop(OP_ADDI, 5, 0, 0, 3), make_uop(OP_ADD, 6, 5, 5, 0), 2'b11);
		for (int k = 0; k < 4; k++) begin
			send_pair(make_uop(OP_SLL, 7, 6, 5, 0), make_uop(OP_XOR, 6, 7, 1, 0), 2'b11);
		end
		// one op per strobe reading the last result
		for (int k = 0; k < 4; k++) begin
			send_pair(make_uop(OP_SUB, 9, 8, 6, 0), '0, 2'b01);
			send_pair('0, make_uop(OP_ADDI, 8, 9, 0, k + 1), 2'b10);
		end
		wait_drain();
	endtask

	task automatic waw_war_mix();
		for (int k = 0; k < 5; k++) begin
			send_pair(make_uop(OP_ADDI, 20, 20, 0, k + 1),
				make_uop(OP_ADD, 21, 20, 21, 0), 2'b11);
			send_pair(make_uop(OP_ADDI, 20, 0, 0, 16 * k),
				make_uop(OP_SUB, 20, 21, 20, 0), 2'b11);
		end
		wait_drain();
	endtask

	task automatic zero_register();
		send_pair(make_uop(OP_ADDI, 0, 0, 0, 'h55), make_uop(OP_ADD, 22, 0, 0, 0), 2'b11);
		send_pair(make_uop(OP_OR, 0, 1, 2, 0), make_uop(OP_ADD, 23, 0, 3, 0), 2'b11);
		send_pair(make_uop(OP_SUB, 24, 3, 0, 0),
			make_uop(OP_ADDI, 25, 0, 0, 'h8000), 2'b11);
		wait_drain();
	endtask

	task automatic random_stream();
		uop_t u [2];
		logic [1:0] en;
		for (int k = 0; k < NUM_RANDOM; k++) begin
			// small register range keeps dependences frequent
			for (int s = 0; s < 2; s++) begin
				u[s].op = opcode_t'($random(seed) & 7);
				u[s].rd = reg_addr_t'($random(seed) & 7);
				u[s].rs = reg_addr_t'($random(seed) & 7);
				u[s].rt = reg_addr_t'($random(seed) & 7);
				u[s].imm = 16'($random(seed));
			end
			en = 2'($random(seed));
			send_pair(u[0], u[1], en);
			if (($random(seed) & 3) == 0)
				@(negedge clk);
		end
		wait_drain();
	endtask

	initial begin
		rstn = 1'b0;
		i_valid = 1'b0;
		i_en = 2'b00;
		i_uop0 = '0;
		i_uop1 = '0;
		errors = 0;
		ops_sent = 0;
		exp_wb = 0;
		wb_count = 0;
		seed = 65061;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
			q_head[r] = 0;
			q_tail[r] = 0;
		end
		repeat (5) @(negedge clk);
		rstn = 1'b1;
		reset_idle();
		each_operation();
		raw_chains();
		waw_war_mix();
		zero_register();
		random_stream();
		for (int r = 0; r < NUM_REGS; r++) begin
			if (q_head[r] != q_tail[r])
				report_failure($sformatf("r%0d still waits for %0d write-backs", r,
					q_tail[r] - q_head[r]));
		end
		check_value("write-back count", wb_count, exp_wb);
		$display("tb_issue_core: %0d errors, %0d ops sent, %0d write-backs",
			errors, ops_sent, wb_count);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// budget grows with every op sent
	initial begin
		@(posedge clk);
		while (cyc <= 20 * ops_sent + 200)
			@(posedge clk);
		$display("timeout: run stalled at cycle %0d with %0d ops sent", cyc, ops_sent);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
hw/issue_pkg.sv
hw/exec_if.sv
hw/wb_if.sv
hw/issue_window.sv
hw/issue_select.sv
hw/reg_file.sv
hw/alu_lane.sv
hw/issue_core.sv
sim/tb_issue_core.sv

// File: Bender.yml
package:
  name: issue_core

sources:
  - hw/issue_pkg.sv
  - hw/exec_if.sv
  - hw/wb_if.sv
  - hw/issue_window.sv
  - hw/issue_select.sv
  - hw/reg_file.sv
  - hw/alu_lane.sv
  - hw/issue_core.sv
  - target: simulation
    files:
      - sim/tb_issue_core.sv
